// File: source/ram_fifo_cfg_pkg.sv
/* ram fifo configuration
   default sizes of the queue words, the pair memory and the counters */
package ram_fifo_cfg_pkg;

    // ceiling log2, at least one bit
    function automatic int addr_w_of(input int depth);
        return (depth > 1) ? $clog2(depth) : 1;
    endfunction

    localparam int data_w_default = 32;
    localparam int pair_depth_default = 512;

    // capacity and count ports
    localparam int cap_w = 16;

    // on-chip buffers, both powers of two
    localparam int ingress_depth = 8;
    localparam int egress_depth = 4;

    // egress occupancy below this allows a memory refill
    localparam int egress_refill_level = 3;

    // pointers carry one extra bit so full and empty differ
    localparam int ingress_cnt_w = addr_w_of(ingress_depth) + 1;
    localparam int egress_cnt_w = addr_w_of(egress_depth) + 1;

endpackage

// File: source/ram_fifo_types_pkg.sv
/* ram fifo types
   per-cycle transfer operation and the causes behind panic */
package ram_fifo_types_pkg;

    // one transfer at most per cycle
    typedef enum logic [1:0] {
        xfer_idle   = 2'd0,
        xfer_bypass = 2'd1,
        xfer_spill  = 2'd2,
        xfer_fill   = 2'd3
    } xfer_op_e;

    // bit positions of the panic vector in the controller
    typedef enum logic [2:0] {
        panic_none         = 3'd0,
        panic_overflow     = 3'd1,
        panic_fill_overrun = 3'd2,
        panic_ram_over     = 3'd3,
        panic_op_clash     = 3'd4
    } panic_e;

endpackage

// File: source/ingress_buffer.sv
/* ingress buffer
   eight-entry input queue, gives up one word or an aligned pair */
`timescale 1ns/100ps

module ingress_buffer #(
    parameter int DATA_W = ram_fifo_cfg_pkg::data_w_default
) (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       softreset,
    input  logic                                       validin,
    input  logic [DATA_W-1:0]                          datain,
    input  ram_fifo_types_pkg::xfer_op_e               xfer_op,
    output logic [ram_fifo_cfg_pkg::ingress_cnt_w-1:0] in_count,
    output logic [DATA_W-1:0]                          head_word,
    output logic [2*DATA_W-1:0]                        pair_word
);
    import ram_fifo_cfg_pkg::*;
    import ram_fifo_types_pkg::*;

    localparam int idx_w = ingress_cnt_w - 1;

    logic [DATA_W-1:0]        mem [ingress_depth];
    logic [ingress_cnt_w-1:0] wr_ptr;
    logic [ingress_cnt_w-1:0] rd_ptr;
    logic [idx_w-1:0]         next_idx;
    logic                     accept;

    // pointers wrap at twice the depth, so the difference is the occupancy
    assign in_count = wr_ptr - rd_ptr;
    assign accept = validin && (in_count != ingress_cnt_w'(ingress_depth));

    assign next_idx = rd_ptr[idx_w-1:0] + 1'b1;
    assign head_word = mem[rd_ptr[idx_w-1:0]];
    // older word in the low half
    assign pair_word = {mem[next_idx], head_word};

    always_ff @(posedge clk) begin
        if (accept) begin
            mem[wr_ptr[idx_w-1:0]] <= datain;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (softreset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            case (xfer_op)
                xfer_bypass: rd_ptr <= rd_ptr + ingress_cnt_w'(1);
                xfer_spill:  rd_ptr <= rd_ptr + ingress_cnt_w'(2);
                default:     rd_ptr <= rd_ptr;
            endcase
        end
    end

endmodule

// File: source/egress_buffer.sv
/* egress buffer
   four-entry output queue with a show-ahead head word,
   filled one word from the bypass or a pair from memory */
`timescale 1ns/100ps

module egress_buffer #(
    parameter int DATA_W = ram_fifo_cfg_pkg::data_w_default
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      softreset,
    input  ram_fifo_types_pkg::xfer_op_e              xfer_op,
    input  logic                                      fill_land,
    input  logic [DATA_W-1:0]                         head_word,
    input  logic [2*DATA_W-1:0]                       rd_pair,
    input  logic                                      readout,
    output logic [ram_fifo_cfg_pkg::egress_cnt_w-1:0] out_count,
    output logic [DATA_W-1:0]                         dataout,
    output logic                                      empty
);
    import ram_fifo_cfg_pkg::*;
    import ram_fifo_types_pkg::*;

    localparam int idx_w = egress_cnt_w - 1;

    logic [DATA_W-1:0]       mem [egress_depth];
    logic [egress_cnt_w-1:0] wr_ptr;
    logic [egress_cnt_w-1:0] rd_ptr;
    logic [idx_w-1:0]        wr_idx;
    logic [idx_w-1:0]        wr_idx_next;
    logic                    pop;

    assign out_count = wr_ptr - rd_ptr;
    assign empty = (out_count == '0);
    assign pop = readout && !empty;
    assign dataout = empty ? '0 : mem[rd_ptr[idx_w-1:0]];

    assign wr_idx = wr_ptr[idx_w-1:0];
    assign wr_idx_next = wr_idx + 1'b1;

    // a landing pair goes low half first
    always_ff @(posedge clk) begin
        if (fill_land) begin
            mem[wr_idx] <= rd_pair[DATA_W-1:0];
            mem[wr_idx_next] <= rd_pair[2*DATA_W-1:DATA_W];
        end else if (xfer_op == xfer_bypass) begin
            mem[wr_idx] <= head_word;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (softreset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (fill_land) begin
                wr_ptr <= wr_ptr + egress_cnt_w'(2);
            end else if (xfer_op == xfer_bypass) begin
                wr_ptr <= wr_ptr + egress_cnt_w'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// File: source/spill_controller.sv
/* spill controller
   picks the transfer of each cycle, keeps the memory pair pointers
   and drives full, count, panic and the memory controls */
`timescale 1ns/100ps

module spill_controller #(
    parameter int   PAIR_DEPTH = ram_fifo_cfg_pkg::pair_depth_default,
    localparam int  ADDR_W = ram_fifo_cfg_pkg::addr_w_of(PAIR_DEPTH)
) (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       softreset,
    input  logic [ram_fifo_cfg_pkg::cap_w-1:0]         capacity,
    input  logic                                       validin,
    input  logic [ram_fifo_cfg_pkg::ingress_cnt_w-1:0] in_count,
    input  logic [ram_fifo_cfg_pkg::egress_cnt_w-1:0]  out_count,
    output ram_fifo_types_pkg::xfer_op_e               xfer_op,
    output logic                                       fill_land,
    output logic                                       ram_cen_n,
    output logic                                       ram_wen_n,
    output logic [ADDR_W-1:0]                          ram_addr,
    output logic                                       full,
    output logic [ram_fifo_cfg_pkg::cap_w-1:0]         count,
    output logic                                       panic
);
    import ram_fifo_cfg_pkg::*;
    import ram_fifo_types_pkg::*;

    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic              wr_wrap;
    logic              rd_wrap;
    logic [cap_w-1:0]  limit_raw;
    logic [cap_w-1:0]  pair_limit;
    logic [cap_w-1:0]  ram_pairs;
    logic              ram_empty;
    logic              ram_full;
    logic              wr_last;
    logic              rd_last;
    logic              in_full;
    logic              out_full;
    logic              fill_ok;
    logic              spill_ok;
    logic              bypass_ok;
    logic [(1 << $bits(panic_e))-1:0] panic_vec;

    // half the capacity rounded up, never beyond the physical memory
    assign limit_raw = {1'b0, capacity[cap_w-1:1]} + cap_w'(capacity[0]);
    assign pair_limit = (limit_raw > cap_w'(PAIR_DEPTH)) ? cap_w'(PAIR_DEPTH) : limit_raw;

    assign ram_pairs = (wr_wrap == rd_wrap) ? cap_w'(wr_ptr) - cap_w'(rd_ptr)
                                            : pair_limit - cap_w'(rd_ptr) + cap_w'(wr_ptr);
    assign ram_empty = (ram_pairs == '0);
    assign ram_full = (ram_pairs >= pair_limit);
    assign wr_last = (cap_w'(wr_ptr) == pair_limit - cap_w'(1));
    assign rd_last = (cap_w'(rd_ptr) == pair_limit - cap_w'(1));

    assign in_full = (in_count == ingress_cnt_w'(ingress_depth));
    assign out_full = (out_count == egress_cnt_w'(egress_depth));

    // memory data is older than anything in ingress, so it goes first
    assign fill_ok = !ram_empty && (out_count < egress_cnt_w'(egress_refill_level))
                     && !fill_land;
    assign spill_ok = (in_count >= ingress_cnt_w'(2)) && (out_full || !ram_empty)
                      && !ram_full;
    assign bypass_ok = ram_empty && (in_count != '0) && !out_full && !fill_land;

    always_comb begin
        if (fill_ok) begin
            xfer_op = xfer_fill;
        end else if (spill_ok) begin
            xfer_op = xfer_spill;
        end else if (bypass_ok) begin
            xfer_op = xfer_bypass;
        end else begin
            xfer_op = xfer_idle;
        end
    end

    // read data shows up one cycle after the fill is issued
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_land <= 1'b0;
        end else if (softreset) begin
            fill_land <= 1'b0;
        end else begin
            fill_land <= (xfer_op == xfer_fill);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            wr_wrap <= 1'b0;
            rd_wrap <= 1'b0;
        end else if (softreset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            wr_wrap <= 1'b0;
            rd_wrap <= 1'b0;
        end else begin
            if (xfer_op == xfer_spill) begin
                wr_ptr <= wr_last ? '0 : wr_ptr + 1'b1;
                wr_wrap <= wr_wrap ^ wr_last;
            end
            if (xfer_op == xfer_fill) begin
                rd_ptr <= rd_last ? '0 : rd_ptr + 1'b1;
                rd_wrap <= rd_wrap ^ rd_last;
            end
        end
    end

    // single port, so the write pointer only while spilling
    assign ram_cen_n = !((xfer_op == xfer_spill) || (xfer_op == xfer_fill));
    assign ram_wen_n = (xfer_op != xfer_spill);
    assign ram_addr = (xfer_op == xfer_spill) ? wr_ptr : rd_ptr;

    assign full = in_full || ram_full;
    assign count = (ram_pairs << 1) + cap_w'(in_count) + cap_w'(out_count);

    always_comb begin
        panic_vec = '0;
        panic_vec[panic_overflow] = validin && full;
        panic_vec[panic_fill_overrun] = fill_land && (out_count > egress_cnt_w'(2));
        panic_vec[panic_ram_over] = ram_full;
        panic_vec[panic_op_clash] = fill_land && (xfer_op == xfer_bypass);
    end

    assign panic = |panic_vec;

endmodule

// File: source/pair_sram.sv
/* pair sram
   single-port synchronous memory of double-width words,
   read data one cycle after the address */
`timescale 1ns/100ps

module pair_sram #(
    parameter int  DATA_W = ram_fifo_cfg_pkg::data_w_default,
    parameter int  PAIR_DEPTH = ram_fifo_cfg_pkg::pair_depth_default,
    localparam int ADDR_W = ram_fifo_cfg_pkg::addr_w_of(PAIR_DEPTH)
) (
    input  logic                clk,
    input  logic                cen_n,
    input  logic                wen_n,
    input  logic [ADDR_W-1:0]   addr,
    input  logic [2*DATA_W-1:0] wdata,
    output logic [2*DATA_W-1:0] rdata
);
    logic [2*DATA_W-1:0] mem [PAIR_DEPTH];

    // rdata holds its value on idle and write cycles
    always_ff @(posedge clk) begin
        if (!cen_n) begin
            if (!wen_n) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// File: source/spill_fifo_top.sv
/* spill fifo top
   queue with on-chip ingress and egress buffers and a pair memory
   for the bulk of its contents */
`timescale 1ns/100ps

module spill_fifo_top #(
    parameter int  DATA_W = ram_fifo_cfg_pkg::data_w_default,
    parameter int  PAIR_DEPTH = ram_fifo_cfg_pkg::pair_depth_default,
    localparam int ADDR_W = ram_fifo_cfg_pkg::addr_w_of(PAIR_DEPTH)
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               softreset,
    input  logic [ram_fifo_cfg_pkg::cap_w-1:0] capacity,
    input  logic                               validin,
    input  logic [DATA_W-1:0]                  datain,
    output logic                               full,
    input  logic                               readout,
    output logic [DATA_W-1:0]                  dataout,
    output logic                               empty,
    output logic [ram_fifo_cfg_pkg::cap_w-1:0] count,
    output logic                               panic
);
    import ram_fifo_cfg_pkg::*;
    import ram_fifo_types_pkg::*;

    xfer_op_e                 xfer_op;
    logic                     fill_land;
    logic [ingress_cnt_w-1:0] in_count;
    logic [egress_cnt_w-1:0]  out_count;
    logic [DATA_W-1:0]        head_word;
    logic [2*DATA_W-1:0]      pair_word;
    logic [2*DATA_W-1:0]      rd_pair;
    logic                     ram_cen_n;
    logic                     ram_wen_n;
    logic [ADDR_W-1:0]        ram_addr;

    spill_controller #(
        .PAIR_DEPTH(PAIR_DEPTH)
    ) spill_controller_inst (
        .clk(clk),
        .rst_n(rst_n),
        .softreset(softreset),
        .capacity(capacity),
        .validin(validin),
        .in_count(in_count),
        .out_count(out_count),
        .xfer_op(xfer_op),
        .fill_land(fill_land),
        .ram_cen_n(ram_cen_n),
        .ram_wen_n(ram_wen_n),
        .ram_addr(ram_addr),
        .full(full),
        .count(count),
        .panic(panic)
    );

    // words offered while full are dropped, also when only the memory is full
    ingress_buffer #(
        .DATA_W(DATA_W)
    ) ingress_buffer_inst (
        .clk(clk),
        .rst_n(rst_n),
        .softreset(softreset),
        .validin(validin && !full),
        .datain(datain),
        .xfer_op(xfer_op),
        .in_count(in_count),
        .head_word(head_word),
        .pair_word(pair_word)
    );

    egress_buffer #(
        .DATA_W(DATA_W)
    ) egress_buffer_inst (
        .clk(clk),
        .rst_n(rst_n),
        .softreset(softreset),
        .xfer_op(xfer_op),
        .fill_land(fill_land),
        .head_word(head_word),
        .rd_pair(rd_pair),
        .readout(readout),
        .out_count(out_count),
        .dataout(dataout),
        .empty(empty)
    );

    pair_sram #(
        .DATA_W(DATA_W),
        .PAIR_DEPTH(PAIR_DEPTH)
    ) pair_sram_inst (
        .clk(clk),
        .cen_n(ram_cen_n),
        .wen_n(ram_wen_n),
        .addr(ram_addr),
        .wdata(pair_word),
        .rdata(rd_pair)
    );

endmodule

// File: verif/spill_fifo_tests.svh
/* spill fifo directed tests
   each task drives the DUT and checks it against the reference queue */

// one new word per cycle, validin released afterwards
task automatic write_words(input int n);
    for (int i = 0; i < n; i++) begin
        @(posedge clk);
        validin <= 1'b1;
        datain <= word_seq;
        word_seq = word_seq + 1'b1;
    end
    @(posedge clk);
    validin <= 1'b0;
endtask

// a fill in flight hides two words from count, so let it land first
task automatic check_idle_count();
    @(posedge clk);
    validin <= 1'b0;
    readout <= 1'b0;
    repeat (6) @(posedge clk);
    @(negedge clk);
    check_count(count, cap_w'(ref_q.size()), "count at idle");
    check_flag(empty, ref_q.size() == 0, "empty at idle");
endtask

// pop until every accepted word came back
task automatic drain_all(input int max_cycles);
    int waited;
    waited = 0;
    @(posedge clk);
    validin <= 1'b0;
    readout <= 1'b1;
    while (ref_q.size() != 0) begin
        @(negedge clk);
        waited++;
        if (waited > max_cycles) begin
            stop_with_error("drain: the queue did not empty in time");
        end
    end
    check_idle_count();
endtask

task automatic after_reset_values();
    @(negedge clk);
    check_flag(empty, 1'b1, "empty after reset");
    check_flag(full, 1'b0, "full after reset");
    check_flag(panic, 1'b0, "panic after reset");
    check_count(count, '0, "count after reset");
endtask

// few words, memory stays unused
task automatic bypass_in_order();
    write_words(3);
    check_idle_count();
    drain_all(20);
endtask

task automatic spill_and_fill();
    for (int i = 0; i < 200; i++) begin
        @(posedge clk);
        validin <= 1'b1;
        datain <= word_seq;
        word_seq = word_seq + 1'b1;
        @(negedge clk);
        check_flag(full, 1'b0, "full below capacity");
    end
    check_idle_count();
    drain_all(400);
endtask

task automatic random_streaming();
    for (int i = 0; i < 2000; i++) begin
        @(posedge clk);
        validin <= 1'($random(seed));
        datain <= DATA_W'($random(seed));
        readout <= 1'($random(seed));
        // quiet points for the depth check
        if (i % 250 == 249) begin
            check_idle_count();
        end
    end
    drain_all(500);
endtask

task automatic capacity_limit();
    int offered;
    int kept;
    // memory pointers restart so they fit the smaller limit
    @(posedge clk);
    softreset <= 1'b1;
    capacity <= cap_w'(20);
    @(posedge clk);
    softreset <= 1'b0;
    // a memory at its limit is itself a panic cause
    panic_allowed = 1'b1;
    offered = 0;
    do begin
        @(posedge clk);
        validin <= 1'b1;
        datain <= word_seq;
        word_seq = word_seq + 1'b1;
        @(negedge clk);
        offered++;
        if (offered > 40) begin
            stop_with_error("full did not rise with a capacity of 20");
        end
    end while (!full);
    if (ref_q.size() > 32) begin
        stop_with_error("more than 32 words accepted before full rose");
    end
    // validin is still high while full
    check_flag(panic, 1'b1, "panic on write while full");
    kept = ref_q.size();
    @(posedge clk);
    validin <= 1'b0;
    @(negedge clk);
    check_count(count, cap_w'(kept), "count after a dropped write");
    drain_all(200);
    panic_allowed = 1'b0;
    @(posedge clk);
    capacity <= cap_w'(1024);
endtask

task automatic soft_reset_flush();
    write_words(30);
    check_idle_count();
    @(posedge clk);
    softreset <= 1'b1;
    @(posedge clk);
    softreset <= 1'b0;
    @(negedge clk);
    check_flag(empty, 1'b1, "empty after soft reset");
    check_count(count, '0, "count after soft reset");
    // fresh data after the flush
    write_words(12);
    check_idle_count();
    drain_all(100);
endtask

// File: verif/spill_fifo_tb.sv
/* spill fifo testbench
   clock, reset, reference queue and compare tasks around the queue subsystem */
`timescale 1ns/100ps

module spill_fifo_tb;
    import ram_fifo_cfg_pkg::*;

    localparam int DATA_W = data_w_default;
    localparam int PAIR_DEPTH = pair_depth_default;
    localparam int clk_period = 10;
    // rough cycles per test, in the order they run
    localparam int test_cycles = 10 + 40 + 450 + 2250 + 120 + 120;
    localparam int margin_cycles = 1000;

    logic              clk;
    logic              rst_n;
    logic              softreset;
    logic [cap_w-1:0]  capacity;
    logic              validin;
    logic [DATA_W-1:0] datain;
    logic              full;
    logic              readout;
    logic [DATA_W-1:0] dataout;
    logic              empty;
    logic [cap_w-1:0]  count;
    logic              panic;

    // accepted words, oldest first
    logic [DATA_W-1:0] ref_q[$];
    logic              panic_allowed;
    logic [DATA_W-1:0] word_seq;
    integer            seed;

    spill_fifo_top #(
        .DATA_W(DATA_W),
        .PAIR_DEPTH(PAIR_DEPTH)
    ) spill_fifo_top_inst (
        .clk(clk),
        .rst_n(rst_n),
        .softreset(softreset),
        .capacity(capacity),
        .validin(validin),
        .datain(datain),
        .full(full),
        .readout(readout),
        .dataout(dataout),
        .empty(empty),
        .count(count),
        .panic(panic)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            stop_with_error($sformatf("Mismatch at %0d ns: %s is %h, expected %h",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_count(input logic [cap_w-1:0] got, input logic [cap_w-1:0] exp,
                               input string what);
        if (got !== exp) begin
            stop_with_error($sformatf("Mismatch at %0d ns: %s is %0d, expected %0d",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_with_error($sformatf("Mismatch at %0d ns: %s is %b, expected %b",
                                      $time, what, got, exp));
        end
    endtask

    // reference follows the strobes as the DUT sees them at the edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (softreset) begin
                ref_q.delete();
            end else begin
                if (readout && !empty) begin
                    if (ref_q.size() == 0) begin
                        stop_with_error("DUT popped a word that was never accepted");
                    end else begin
                        check_word(dataout, ref_q.pop_front(), "dataout on pop");
                    end
                end
                // words offered while full are dropped
                if (validin && !full) begin
                    ref_q.push_back(datain);
                end
            end
        end
    end

    // combinational outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (!panic_allowed) begin
                check_flag(panic, 1'b0, "panic");
            end
            if (empty) begin
                check_word(dataout, '0, "dataout while empty");
            end
        end
    end

    `include "spill_fifo_tests.svh"

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        softreset = 1'b0;
        capacity = cap_w'(1024);
        validin = 1'b0;
        datain = '0;
        readout = 1'b0;
        panic_allowed = 1'b0;
        word_seq = DATA_W'(32'h5a00_0001);
        seed = 32'ha7f3_e95b;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        after_reset_values();
        bypass_in_order();
        spill_and_fill();
        random_streaming();
        capacity_limit();
        soft_reset_flush();
        $display("Result: PASSED");
        $finish;
    end

    // watchdog
    initial begin
        #((test_cycles + margin_cycles) * clk_period);
        stop_with_error("timeout: tests did not finish");
    end

endmodule

// File: verilog.f
+incdir+verif
source/ram_fifo_cfg_pkg.sv
source/ram_fifo_types_pkg.sv
source/ingress_buffer.sv
source/egress_buffer.sv
source/spill_controller.sv
source/pair_sram.sv
source/spill_fifo_top.sv
verif/spill_fifo_tb.sv

// File: Makefile
# Verilator flow for the spill fifo testbench

TOP := spill_fifo_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

# the run passes only if the pass line shows up in the output
sim:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir
